// ==== nocPkg.sv ====
package nocPkg;

  parameter int NUM_PORTS  = 5;
  parameter int LEN_W      = 12;
  parameter int ID_W       = 3;
  parameter int GRANT_W    = NUM_PORTS + 1;  // IDLE plus one bit per input.
  parameter int DEF_DATA_W = 32;
  parameter int DEF_CNT_W  = 16;

  // Input ports in priority order.
  typedef enum logic [2:0] {
    LOCAL = 3'd0,
    NORTH = 3'd1,
    EAST  = 3'd2,
    WEST  = 3'd3,
    SOUTH = 3'd4
  } portE;

  typedef enum logic [ID_W-1:0] {
    BODY = 3'd0,
    HEAD = 3'd1,  // Carries the hold quota in its length field.
    TAIL = 3'd2
  } flitIdE;

  // One-hot arbiter state, bit n+1 grants input n.
  typedef enum logic [GRANT_W-1:0] {
    IDLE      = 6'b000001,
    GNT_LOCAL = 6'b000010,
    GNT_NORTH = 6'b000100,
    GNT_EAST  = 6'b001000,
    GNT_WEST  = 6'b010000,
    GNT_SOUTH = 6'b100000
  } grantT;

endpackage

// ==== flitPortIf.sv ====
`timescale 1ns/1ns

interface flitPortIf #(
  parameter int DATA_W = nocPkg::DEF_DATA_W
) ();
  import nocPkg::*;

  logic              req;
  flitIdE            flitId;
  logic [LEN_W-1:0]  length;
  logic [DATA_W-1:0] data;

  modport source (
    output req, flitId, length, data
  );

  // Arbiter only needs the header fields.
  modport arb (
    input req, flitId, length
  );

  modport sel (
    input data, req
  );

endinterface

// ==== grantTimer.sv ====
`timescale 1ns/1ns

module grantTimer (
  input  logic                    clk,
  input  logic                    rst,
  input  nocPkg::flitIdE          flitId,
  input  logic [nocPkg::LEN_W-1:0] length,
  input  logic                    runTimer,
  output logic                    timesUp
);
  import nocPkg::*;

  logic [LEN_W-1:0] quota;
  logic [LEN_W-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      quota <= '0;
      count <= '0;
    end
    else
    begin
      // Any header reloads the quota, granted or not.
      if (flitId == HEAD)
      begin
        quota <= length;
      end
      if (runTimer)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0;  // Idle timer restarts from zero.
      end
    end
  end

  assign timesUp = (count == quota);

endmodule

// ==== outputArbiter.sv ====
`timescale 1ns/1ns

module outputArbiter (
  input  logic                        clk,
  input  logic                        rst,
  flitPortIf.arb                      lPort,
  flitPortIf.arb                      nPort,
  flitPortIf.arb                      ePort,
  flitPortIf.arb                      wPort,
  flitPortIf.arb                      sPort,
  input  logic [nocPkg::NUM_PORTS-1:0] enMask,
  output nocPkg::grantT               grant
);
  import nocPkg::*;

  logic [NUM_PORTS-1:0] reqs;
  logic [NUM_PORTS-1:0] maskedReq;
  logic [NUM_PORTS-1:0] runTimer;
  logic [NUM_PORTS-1:0] timesUp;
  flitIdE               flitIds [NUM_PORTS];
  logic [LEN_W-1:0]     lengths [NUM_PORTS];
  grantT                nextGrant;

  // Search order starts at start and wraps round.
  function automatic grantT pickFirst(
    input logic [NUM_PORTS-1:0] cand,
    input int                   start
  );
    grantT pick;
    int    idx;
    pick = IDLE;
    for (int k = NUM_PORTS - 1; k >= 0; k--)
    begin
      idx = (start + k) % NUM_PORTS;
      if (cand[idx])
      begin
        pick = grantT'(GRANT_W'(1) << (idx + 1));
      end
    end
    return pick;
  endfunction

  assign reqs = {sPort.req, wPort.req, ePort.req, nPort.req, lPort.req};
  assign maskedReq = reqs & enMask;

  assign flitIds[LOCAL] = lPort.flitId;
  assign flitIds[NORTH] = nPort.flitId;
  assign flitIds[EAST]  = ePort.flitId;
  assign flitIds[WEST]  = wPort.flitId;
  assign flitIds[SOUTH] = sPort.flitId;

  assign lengths[LOCAL] = lPort.length;
  assign lengths[NORTH] = nPort.length;
  assign lengths[EAST]  = ePort.length;
  assign lengths[WEST]  = wPort.length;
  assign lengths[SOUTH] = sPort.length;

  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : gTimer
    grantTimer timerInst (
      .clk      (clk),
      .rst      (rst),
      .flitId   (flitIds[i]),
      .length   (lengths[i]),
      .runTimer (runTimer[i]),
      .timesUp  (timesUp[i])
    );
  end

  always_comb
  begin
    nextGrant = IDLE;
    runTimer  = '0;
    if (grant == IDLE)
    begin
      nextGrant = pickFirst(maskedReq, 0);  // Fixed order from idle.
    end
    else
    begin
      for (int i = 0; i < NUM_PORTS; i++)
      begin
        if (grant[i+1])
        begin
          if (maskedReq[i] && !timesUp[i])
          begin
            runTimer[i] = 1'b1;
            nextGrant   = grant;
          end
          else
          begin
            // Holder drops out of the search.
            nextGrant = pickFirst(maskedReq & ~(NUM_PORTS'(1) << i), i + 1);
          end
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= IDLE;
    end
    else
    begin
      grant <= nextGrant;
    end
  end

  gntOneHot: assert property (@(posedge clk) disable iff (rst)
    $onehot(grant));

  // Expired hold must hand over or go idle on the next edge.
  holdExpires: assert property (@(posedge clk) disable iff (rst)
    |(grant[NUM_PORTS:1] & timesUp) |=> grant != $past(grant));

  gntFromReq: assert property (@(posedge clk) disable iff (rst)
    grant != IDLE |-> |(grant[NUM_PORTS:1] & $past(maskedReq)));

endmodule

// ==== flitSelector.sv ====
`timescale 1ns/1ns

module flitSelector #(
  parameter int DATA_W = nocPkg::DEF_DATA_W
) (
  input  logic              clk,
  input  logic              rst,
  flitPortIf.sel            lPort,
  flitPortIf.sel            nPort,
  flitPortIf.sel            ePort,
  flitPortIf.sel            wPort,
  flitPortIf.sel            sPort,
  input  nocPkg::grantT     grant,
  output logic [DATA_W-1:0] outData,
  output logic              outValid,
  output nocPkg::portE      outSrc
);
  import nocPkg::*;

  logic [DATA_W-1:0]    datas [NUM_PORTS];
  logic [NUM_PORTS-1:0] reqs;
  logic [DATA_W-1:0]    selData;
  logic                 selReq;
  portE                 selSrc;

  assign datas[LOCAL] = lPort.data;
  assign datas[NORTH] = nPort.data;
  assign datas[EAST]  = ePort.data;
  assign datas[WEST]  = wPort.data;
  assign datas[SOUTH] = sPort.data;
  assign reqs = {sPort.req, wPort.req, ePort.req, nPort.req, lPort.req};

  // One-hot AND-OR crossbar leg.
  always_comb
  begin
    selData = '0;
    selReq  = 1'b0;
    selSrc  = LOCAL;
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      if (grant[i+1])
      begin
        selData = selData | datas[i];
        selReq  = reqs[i];
        selSrc  = portE'(i);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      outSrc   <= LOCAL;
    end
    else
    begin
      outValid <= selReq;  // Low while idle.
      if (selReq)
      begin
        outSrc <= selSrc;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (selReq)
    begin
      outData <= selData;
    end
  end

endmodule

// ==== arbCtrlRegs.sv ====
`timescale 1ns/1ns

module arbCtrlRegs #(
  parameter int CNT_W = nocPkg::DEF_CNT_W
) (
  input  logic                         clk,
  input  logic                         rst,
  input  nocPkg::grantT                grant,
  input  logic                         regWe,
  input  logic [2:0]                   regAddr,
  input  logic [15:0]                  regWData,
  output logic [CNT_W-1:0]             regRData,
  output logic [nocPkg::NUM_PORTS-1:0] enMask
);
  import nocPkg::*;

  logic [NUM_PORTS-1:0] prevGnt;
  logic [NUM_PORTS-1:0] gntRise;
  logic [CNT_W-1:0]     grantCnt [NUM_PORTS];

  assign gntRise = grant[NUM_PORTS:1] & ~prevGnt;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      enMask <= '1;  // All inputs enabled.
    end
    else if (regWe)
    begin
      enMask <= regWData[NUM_PORTS-1:0];
    end
  end

  // Count grant entries per input.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      prevGnt <= '0;
      for (int i = 0; i < NUM_PORTS; i++)
      begin
        grantCnt[i] <= '0;
      end
    end
    else
    begin
      prevGnt <= grant[NUM_PORTS:1];
      for (int i = 0; i < NUM_PORTS; i++)
      begin
        if (gntRise[i])
        begin
          grantCnt[i] <= grantCnt[i] + 1'b1;
        end
      end
    end
  end

  always_comb
  begin
    regRData = '0;
    if (regAddr == 3'd0)
    begin
      regRData = CNT_W'(enMask);
    end
    else if (regAddr <= 3'(NUM_PORTS))
    begin
      regRData = grantCnt[regAddr - 3'd1];  // Counters sit at 1 to 5.
    end
  end

  maskOnlyWrite: assert property (@(posedge clk) disable iff (rst)
    regWe |-> regAddr == 3'd0);

endmodule

// ==== routerOutPort.sv ====
`timescale 1ns/1ns

module routerOutPort #(
  parameter int DATA_W = nocPkg::DEF_DATA_W,
  parameter int CNT_W  = nocPkg::DEF_CNT_W
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     lReq,
  input  nocPkg::flitIdE           lFlitId,
  input  logic [nocPkg::LEN_W-1:0] lLength,
  input  logic [DATA_W-1:0]        lData,
  input  logic                     nReq,
  input  nocPkg::flitIdE           nFlitId,
  input  logic [nocPkg::LEN_W-1:0] nLength,
  input  logic [DATA_W-1:0]        nData,
  input  logic                     eReq,
  input  nocPkg::flitIdE           eFlitId,
  input  logic [nocPkg::LEN_W-1:0] eLength,
  input  logic [DATA_W-1:0]        eData,
  input  logic                     wReq,
  input  nocPkg::flitIdE           wFlitId,
  input  logic [nocPkg::LEN_W-1:0] wLength,
  input  logic [DATA_W-1:0]        wData,
  input  logic                     sReq,
  input  nocPkg::flitIdE           sFlitId,
  input  logic [nocPkg::LEN_W-1:0] sLength,
  input  logic [DATA_W-1:0]        sData,
  input  logic                     regWe,
  input  logic [2:0]               regAddr,
  input  logic [15:0]              regWData,
  output logic [CNT_W-1:0]         regRData,
  output nocPkg::grantT            grant,
  output logic [DATA_W-1:0]        outData,
  output logic                     outValid,
  output nocPkg::portE             outSrc
);
  import nocPkg::*;

  logic [NUM_PORTS-1:0] enMask;

  flitPortIf #(.DATA_W(DATA_W)) lIf ();
  flitPortIf #(.DATA_W(DATA_W)) nIf ();
  flitPortIf #(.DATA_W(DATA_W)) eIf ();
  flitPortIf #(.DATA_W(DATA_W)) wIf ();
  flitPortIf #(.DATA_W(DATA_W)) sIf ();

  assign lIf.req = lReq;
  assign lIf.flitId = lFlitId;
  assign lIf.length = lLength;
  assign lIf.data = lData;
  assign nIf.req = nReq;
  assign nIf.flitId = nFlitId;
  assign nIf.length = nLength;
  assign nIf.data = nData;
  assign eIf.req = eReq;
  assign eIf.flitId = eFlitId;
  assign eIf.length = eLength;
  assign eIf.data = eData;
  assign wIf.req = wReq;
  assign wIf.flitId = wFlitId;
  assign wIf.length = wLength;
  assign wIf.data = wData;
  assign sIf.req = sReq;
  assign sIf.flitId = sFlitId;
  assign sIf.length = sLength;
  assign sIf.data = sData;

  outputArbiter arbInst (
    .clk    (clk),
    .rst    (rst),
    .lPort  (lIf.arb),
    .nPort  (nIf.arb),
    .ePort  (eIf.arb),
    .wPort  (wIf.arb),
    .sPort  (sIf.arb),
    .enMask (enMask),
    .grant  (grant)
  );

  flitSelector #(.DATA_W(DATA_W)) selInst (
    .clk      (clk),
    .rst      (rst),
    .lPort    (lIf.sel),
    .nPort    (nIf.sel),
    .ePort    (eIf.sel),
    .wPort    (wIf.sel),
    .sPort    (sIf.sel),
    .grant    (grant),
    .outData  (outData),
    .outValid (outValid),
    .outSrc   (outSrc)
  );

  arbCtrlRegs #(.CNT_W(CNT_W)) regsInst (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .regWe    (regWe),
    .regAddr  (regAddr),
    .regWData (regWData),
    .regRData (regRData),
    .enMask   (enMask)
  );

endmodule

// ==== tbRouterOutPort.sv ====
`timescale 1ns/1ns

module tbRouterOutPort;
  import nocPkg::*;

  logic             clk;
  logic             rst;
  logic [4:0]       reqV;
  flitIdE           fid [NUM_PORTS];
  logic [LEN_W-1:0] len [NUM_PORTS];
  logic [31:0]      dat [NUM_PORTS];
  logic             regWe;
  logic [2:0]       regAddr;
  logic [15:0]      regWData;
  logic [15:0]      regRData;
  grantT            grant;
  logic [31:0]      outData;
  logic             outValid;
  portE             outSrc;

  // Reference model state.
  logic [5:0]       mState;
  logic [LEN_W-1:0] mQuota [NUM_PORTS];
  logic [LEN_W-1:0] mCnt [NUM_PORTS];
  logic [4:0]       mMask;
  int               mGrants [NUM_PORTS];
  logic             expValid;
  logic [31:0]      expData;
  logic [2:0]       expSrc;

  integer seed;
  int     errCount;
  int     errAtStart;
  int     testsPassed;
  int     testsFailed;

  routerOutPort #(.DATA_W(32), .CNT_W(16)) routerOutPort_inst (
    .lReq(reqV[0]), .lFlitId(fid[0]), .lLength(len[0]), .lData(dat[0]),
    .nReq(reqV[1]), .nFlitId(fid[1]), .nLength(len[1]), .nData(dat[1]),
    .eReq(reqV[2]), .eFlitId(fid[2]), .eLength(len[2]), .eData(dat[2]),
    .wReq(reqV[3]), .wFlitId(fid[3]), .wLength(len[3]), .wData(dat[3]),
    .sReq(reqV[4]), .sFlitId(fid[4]), .sLength(len[4]), .sData(dat[4]),
    .*
  );

  always #10 clk = ~clk;

  function automatic logic [5:0] refNextGrant(input logic [5:0] cur, input logic [4:0] mreq,
                                              input logic [4:0] tUp);
    logic [5:0] nxt;
    bit         found;
    int         h;
    int         idx;
    nxt = 6'b000001;
    found = 0;
    h = -1;
    for (int i = 0; i < 5; i++)
    begin
      if (cur[i+1])
        h = i;
    end
    if (h >= 0 && mreq[h] && !tUp[h])
      return cur;  // Holder keeps the output.
    for (int k = 0; k < 5; k++)
    begin
      idx = (h < 0) ? k : (h + 1 + k) % 5;
      if (!found && mreq[idx] && idx != h)
      begin
        nxt = 6'b000010 << idx;
        found = 1;
      end
    end
    return nxt;
  endfunction

  task automatic resetModel();
    mState = 6'b000001;
    mMask = 5'h1f;
    expValid = 1'b0;
    for (int i = 0; i < 5; i++)
    begin
      mQuota[i] = '0;
      mCnt[i] = '0;
      mGrants[i] = 0;
    end
  endtask

  task automatic stepModel();
    logic [4:0] tUp;
    logic [5:0] nxt;
    int         h;
    h = -1;
    for (int i = 0; i < 5; i++)
    begin
      tUp[i] = (mCnt[i] == mQuota[i]);
      if (mState[i+1])
        h = i;
    end
    nxt = refNextGrant(mState, reqV & mMask, tUp);
    expValid = 1'b0;
    if (h >= 0)
    begin
      if (reqV[h])
      begin
        expValid = 1'b1;
        expData = dat[h];
        expSrc = 3'(h);
      end
    end
    for (int i = 0; i < 5; i++)
    begin
      if (nxt[i+1] && !mState[i+1])
        mGrants[i]++;
      mCnt[i] = (i == h && nxt == mState) ? mCnt[i] + 1'b1 : '0;
      if (fid[i] == HEAD)
        mQuota[i] = len[i];
    end
    if (regWe)
      mMask = regWData[4:0];
    mState = nxt;
  endtask

  task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
      errCount++;
      $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  // Model steps on the edge and the DUT is compared just after.
  always @(posedge clk)
  begin
    if (rst)
      resetModel();
    else
      stepModel();
    #1;
    if (!rst)
    begin
      checkVal("grant", 32'(mState), 32'(grant));
      checkVal("outValid", 32'(expValid), 32'(outValid));
      if (expValid)
      begin
        checkVal("outData", expData, outData);
        checkVal("outSrc", 32'(expSrc), 32'(outSrc));
      end
    end
  end

  task automatic waitGrant(input logic [5:0] g, input int limit);
    int n;
    n = 0;
    while (grant !== g && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    if (grant !== g)
    begin
      errCount++;
      $display("Timeout: grant did not reach %b within %0d cycles", g, limit);
    end
  endtask

  task automatic checkHold(input logic [5:0] g, input int cycles);
    int n;
    waitGrant(g, 20);
    n = 0;
    while (grant === g && n < 20)
    begin
      @(negedge clk);
      n++;
    end
    checkVal("holdCycles", cycles, n);
  endtask

  task automatic releaseInputs();
    @(negedge clk);
    reqV = '0;
    for (int i = 0; i < 5; i++)
      fid[i] = BODY;
    waitGrant(6'b000001, 20);
    @(negedge clk);
  endtask

  task automatic readReg(input logic [2:0] addr, input int expVal, input string name);
    @(negedge clk);
    regAddr = addr;
    #1;
    checkVal(name, 32'(expVal), 32'(regRData));
  endtask

  task automatic writeMask(input logic [4:0] mask);
    @(negedge clk);
    regWe = 1'b1;
    regAddr = 3'd0;
    regWData = 16'(mask);
    @(negedge clk);
    regWe = 1'b0;
  endtask

  task automatic finishTest(input string name);
    if (errCount == errAtStart)
    begin
      testsPassed++;
      $display("Test %s: passed", name);
    end
    else
    begin
      testsFailed++;
      $display("Test %s: failed with %0d errors", name, errCount - errAtStart);
    end
    errAtStart = errCount;
  endtask

  initial
  begin
    int n;
    seed = 32'hec5a;
    clk = 1'b0;
    rst = 1'b1;
    reqV = '0;
    regWe = 1'b0;
    regAddr = '0;
    regWData = '0;
    errCount = 0;
    errAtStart = 0;
    testsPassed = 0;
    testsFailed = 0;
    for (int i = 0; i < 5; i++)
    begin
      fid[i] = BODY;
      len[i] = '0;
      dat[i] = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    @(negedge clk);
    checkVal("grant", 32'(IDLE), 32'(grant));
    checkVal("outValid", 32'(0), 32'(outValid));
    readReg(3'd0, 31, "mask");
    for (int i = 1; i <= 5; i++)
      readReg(3'(i), 0, "grantCnt");
    repeat (5) @(negedge clk);
    checkVal("grant", 32'(IDLE), 32'(grant));
    finishTest("1 reset and idle");

    @(negedge clk);
    for (int i = 0; i < 5; i++)
      dat[i] = $random(seed);
    reqV = 5'h1f;
    waitGrant(GNT_LOCAL, 10);
    n = 0;
    while (outValid !== 1'b1 && n < 10)
    begin
      @(negedge clk);
      n++;
    end
    if (outValid !== 1'b1)
    begin
      errCount++;
      $display("Timeout: no valid output flit after the Local grant");
    end
    checkVal("outData", dat[0], outData);
    checkVal("outSrc", 32'(LOCAL), 32'(outSrc));
    releaseInputs();
    finishTest("2 priority from idle");

    // Header flits load the quotas before any request.
    @(negedge clk);
    len[0] = 12'd3;
    len[1] = 12'd1;
    len[2] = 12'd0;
    len[3] = 12'd2;
    len[4] = 12'd4;
    for (int i = 0; i < 5; i++)
      fid[i] = HEAD;
    @(negedge clk);
    for (int i = 0; i < 5; i++)
      fid[i] = BODY;
    reqV = 5'h1f;
    checkHold(GNT_LOCAL, 4);
    checkHold(GNT_NORTH, 2);
    checkHold(GNT_EAST, 1);
    checkHold(GNT_WEST, 3);
    checkHold(GNT_SOUTH, 5);
    releaseInputs();
    finishTest("3 quota hold and rotation");

    writeMask(5'b10101);
    reqV = 5'h1f;
    readReg(3'd0, 21, "mask");
    for (int c = 0; c < 30; c++)
    begin
      @(negedge clk);
      if (grant === GNT_NORTH || grant === GNT_WEST)
      begin
        errCount++;
        $display("Masked input was granted at %0t", $time);
      end
    end
    releaseInputs();
    writeMask(5'h1f);
    finishTest("4 masking");

    for (int c = 0; c < 400; c++)
    begin
      @(negedge clk);
      reqV = 5'($random(seed));
      for (int i = 0; i < 5; i++)
      begin
        fid[i] = flitIdE'(3'(($random(seed) & 32'h7fffffff) % 3));
        len[i] = LEN_W'($random(seed) & 7);
        dat[i] = $random(seed);
      end
    end
    releaseInputs();
    finishTest("5 random traffic");

    for (int i = 0; i < 5; i++)
      readReg(3'(i + 1), mGrants[i], "grantCnt");
    finishTest("6 grant counters");

    $display("Tests passed: %0d, failed: %0d, check errors: %0d",
             testsPassed, testsFailed, errCount);
    if (testsFailed == 0 && errCount == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== routerOutPort.f ====
nocPkg.sv
flitPortIf.sv
grantTimer.sv
outputArbiter.sv
flitSelector.sv
arbCtrlRegs.sv
routerOutPort.sv
tbRouterOutPort.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tbRouterOutPort \
  -f routerOutPort.f > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/VtbRouterOutPort > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log
grep -q "^=== PASS ===$" sim.log && echo "Result: pass" || { echo "Result: fail"; exit 1; }
